// ==== run.sh ====
#!/usr/bin/env bash
# Build with Verilator, run, and decide on the log contents
cd "$(dirname "$0")" || exit 1
rm -f sim.log
verilator --binary --timing -f src.f --top-module rvCoreTb -o simv &&
./obj_dir/simv > sim.log 2>&1 ||
echo "Build or simulation returned an error"
cat sim.log 2>/dev/null
grep -q "All tests passed" sim.log 2>/dev/null && exit 0 || exit 1

// ==== src.f ====
src/rvPkg.sv
src/rvDecoder.sv
src/rvRegFile.sv
src/rvAlu.sv
src/rvLoadStore.sv
src/rvCore.sv
tests/rvCoreTb.sv

// ==== src/rvAlu.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Integer ALU of the RV32I core, combinational
// Shared adder, one 33-bit subtractor for SUB and all compares,
// single right shifter with bit reversal for left shifts,
// logic ops and the conditional branch predicate
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvAlu (
   input  rvPkg::decodedT dec,
   input  rvPkg::wordT    rs1Val,
   input  rvPkg::wordT    rs2Val,
   output rvPkg::wordT    aluOut,
   output rvPkg::wordT    aluPlus,     // rs1 + op2, also the JALR target
   output logic           predicate    // Branch taken
);
   import rvPkg::*;

   // Reverse bit order, turns the right shifter into a left shifter
   function automatic wordT flip(input wordT x);
      wordT y;
      for (int i = 0; i < xlen; i++) begin
         y[i] = x[xlen-1-i];
      end
      return y;
   endfunction

   wordT              aluIn1;
   wordT              aluIn2;
   logic [xlen:0]     aluMinus;
   logic              lt;
   logic              ltu;
   logic              eq;
   wordT              shiftIn;
   logic signed [xlen:0] shiftWide;
   wordT              shiftRight;
   wordT              shiftLeft;
   logic              doSub;

   assign aluIn1 = rs1Val;
   // Register operand for ALU-reg and branches, I immediate otherwise
   assign aluIn2 = (dec.isAluReg | dec.isBranch) ? rs2Val : dec.iImm;

   assign aluPlus = aluIn1 + aluIn2;

   // rs1 - rs2 computed as rs1 + ~rs2 + 1 on 33 bits, bit 32 is the borrow
   assign aluMinus = {1'b1, ~aluIn2} + {1'b0, aluIn1} + {{xlen{1'b0}}, 1'b1};
   assign ltu = aluMinus[xlen];
   assign lt  = (aluIn1[xlen-1] ^ aluIn2[xlen-1]) ? aluIn1[xlen-1] : aluMinus[xlen];
   assign eq  = (aluMinus[xlen-1:0] == '0);

   assign shiftIn = dec.funct3Is[1] ? flip(aluIn1) : aluIn1;  // SLL goes through reversed
   // Bit 32 carries the sign for SRA, zero for SRL and SLL
   assign shiftWide  = $signed({dec.subBit & aluIn1[xlen-1], shiftIn}) >>> aluIn2[4:0];
   assign shiftRight = shiftWide[xlen-1:0];
   assign shiftLeft  = flip(shiftRight);

   // SUB only in register form, ADDI reuses bit 30 as immediate
   assign doSub = dec.subBit & dec.regOpBit;

   always_comb begin
      aluOut = '0;
      if (dec.funct3Is[0]) aluOut |= doSub ? aluMinus[xlen-1:0] : aluPlus;   // ADD, SUB
      if (dec.funct3Is[1]) aluOut |= shiftLeft;                 // SLL
      if (dec.funct3Is[2]) aluOut |= {{(xlen-1){1'b0}}, lt};    // SLT
      if (dec.funct3Is[3]) aluOut |= {{(xlen-1){1'b0}}, ltu};   // SLTU
      if (dec.funct3Is[4]) aluOut |= aluIn1 ^ aluIn2;           // XOR
      if (dec.funct3Is[5]) aluOut |= shiftRight;                // SRL, SRA
      if (dec.funct3Is[6]) aluOut |= aluIn1 | aluIn2;           // OR
      if (dec.funct3Is[7]) aluOut |= aluIn1 & aluIn2;           // AND
   end

   // funct3 2 and 3 are not branch encodings
   assign predicate = (dec.funct3Is[0] &  eq)  |   // BEQ
                      (dec.funct3Is[1] & ~eq)  |   // BNE
                      (dec.funct3Is[4] &  lt)  |   // BLT
                      (dec.funct3Is[5] & ~lt)  |   // BGE
                      (dec.funct3Is[6] &  ltu) |   // BLTU
                      (dec.funct3Is[7] & ~ltu);    // BGEU

endmodule

// ==== src/rvCore.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Multi-cycle RV32I core, top level
// Program counter and next-PC logic, latched instruction,
// one-hot FSM fetch / waitInstr / execute / waitMem,
// write-back selection and the memory bus
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvCore (
   input  logic          clk,
   input  logic          reset,     // Synchronous, active low
   output rvPkg::memReqT memReq,
   input  rvPkg::memRspT memRsp
);
   import rvPkg::*;

   stateT                state;
   logic [addrWidth-1:0] pc;
   wordT                 instr;      // Instruction under execution

   decodedT              dec;
   wordT                 rs1Val;
   wordT                 rs2Val;
   wordT                 aluOut;
   wordT                 aluPlus;
   logic                 predicate;
   logic [addrWidth-1:0] lsAddr;
   wordT                 loadData;
   wordT                 storeData;
   logic [3:0]           storeMask;

   logic [addrWidth-1:0] pcPlus4;
   logic [addrWidth-1:0] pcPlusImm;
   logic [addrWidth-1:0] pcNext;
   wordT                 immSel;
   logic                 memIdle;
   logic                 needMem;
   logic                 instrReady;
   logic                 writeEn;
   wordT                 writeData;

   rvDecoder decoder0 (
      .instr (instr),
      .dec   (dec)
   );

   // Sources read from the incoming word, before it is latched
   rvRegFile regFile0 (
      .clk       (clk),
      .load      (instrReady),
      .rs1Id     (memRsp.rdata[19:15]),
      .rs2Id     (memRsp.rdata[24:20]),
      .rs1Val    (rs1Val),
      .rs2Val    (rs2Val),
      .writeEn   (writeEn),
      .rd        (dec.rd),
      .writeData (writeData)
   );

   rvAlu alu0 (
      .dec       (dec),
      .rs1Val    (rs1Val),
      .rs2Val    (rs2Val),
      .aluOut    (aluOut),
      .aluPlus   (aluPlus),
      .predicate (predicate)
   );

   rvLoadStore loadStore0 (
      .dec       (dec),
      .rs1Val    (rs1Val),
      .rs2Val    (rs2Val),
      .rdata     (memRsp.rdata),
      .lsAddr    (lsAddr),
      .loadData  (loadData),
      .storeData (storeData),
      .storeMask (storeMask)
   );

   assign memIdle    = ~memRsp.rbusy & ~memRsp.wbusy;
   assign needMem    = dec.isLoad | dec.isStore;
   assign instrReady = state[waitInstrBit] & ~memRsp.rbusy;

   // One adder for JAL, AUIPC and branch targets
   assign immSel    = dec.isJal ? dec.jImm : dec.isAuipc ? dec.uImm : dec.bImm;
   assign pcPlus4   = pc + addrWidth'(4);
   assign pcPlusImm = pc + immSel[addrWidth-1:0];

   always_comb begin
      if (dec.isJalr) begin
         pcNext = {aluPlus[addrWidth-1:1], 1'b0};   // Bit 0 cleared
      end else if (dec.isJal | (dec.isBranch & predicate)) begin
         pcNext = pcPlusImm;
      end else begin
         pcNext = pcPlus4;
      end
   end

   // Loads write back when leaving waitMem, everything else in execute
   assign writeEn =
      (state[executeBit] & (dec.isAluImm | dec.isAluReg | dec.isLui | dec.isAuipc |
                            dec.isJal | dec.isJalr)) |
      (state[waitMemBit] & dec.isLoad & memIdle);

   assign writeData =
      ({xlen{dec.isLui}}                  & dec.uImm)                                  |
      ({xlen{dec.isAluImm | dec.isAluReg}} & aluOut)                                   |
      ({xlen{dec.isAuipc}}                & {{(xlen-addrWidth){1'b0}}, pcPlusImm})     |
      ({xlen{dec.isJal | dec.isJalr}}     & {{(xlen-addrWidth){1'b0}}, pcPlus4})       |
      ({xlen{dec.isLoad}}                 & loadData);

   // Memory bus, PC during fetch, effective address otherwise
   always_comb begin
      memReq.addr  = {{(xlen-addrWidth){1'b0}},
                      (state[fetchBit] | state[waitInstrBit]) ? pc : lsAddr};
      memReq.wdata = storeData;
      memReq.wmask = {4{state[executeBit] & dec.isStore}} & storeMask;
      memReq.rstrb = state[fetchBit] | (state[executeBit] & dec.isLoad);
   end

   always_ff @(posedge clk) begin
      if (!reset) begin
         state <= waitMemState;                // Wait for memory to go idle first
         pc    <= resetAddr[addrWidth-1:0];
         instr <= nopInstr;                    // Nothing to write back on exit
      end else begin
         case (1'b1)
            state[fetchBit]: begin
               state <= waitInstrState;        // rstrb pulsed this cycle
            end
            state[waitInstrBit]: begin
               if (!memRsp.rbusy) begin
                  instr <= memRsp.rdata;
                  state <= executeState;
               end
            end
            state[executeBit]: begin
               pc    <= pcNext;
               state <= needMem ? waitMemState : fetchState;
            end
            default: begin                     // waitMem
               if (memIdle) begin
                  state <= fetchState;
               end
            end
         endcase
      end
   end

endmodule

// ==== src/rvDecoder.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// RV32I instruction decoder, purely combinational
// Register fields, one-hot funct3, the five immediate formats
// and one flag per major opcode group
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvDecoder (
   input  rvPkg::wordT    instr,   // Latched instruction word
   output rvPkg::decodedT dec
);
   import rvPkg::*;

   logic [4:0] opcode;

   assign opcode = instr[6:2];     // Bits 1..0 are always 11 in RV32I

   always_comb begin
      // Register fields
      dec.rd       = instr[11:7];
      dec.rs1Id    = instr[19:15];
      dec.rs2Id    = instr[24:20];

      dec.funct3   = instr[14:12];
      dec.funct3Is = 8'b0000_0001 << instr[14:12];   // One-hot ALU / branch function
      dec.subBit   = instr[30];
      dec.regOpBit = instr[5];     // Separates ADD/SUB from ADDI

      // Immediates, all sign extended from bit 31
      dec.iImm = {{21{instr[31]}}, instr[30:20]};
      dec.sImm = {{21{instr[31]}}, instr[30:25], instr[11:7]};
      dec.bImm = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
      dec.uImm = {instr[31:12], 12'b0};
      dec.jImm = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};

      // Opcode class, default is a no-op
      dec.isLoad   = 1'b0;
      dec.isStore  = 1'b0;
      dec.isAluImm = 1'b0;
      dec.isAluReg = 1'b0;
      dec.isLui    = 1'b0;
      dec.isAuipc  = 1'b0;
      dec.isBranch = 1'b0;
      dec.isJal    = 1'b0;
      dec.isJalr   = 1'b0;

      case (opcode)
         opLoad:   dec.isLoad   = 1'b1;   // rd <- mem[rs1 + iImm]
         opStore:  dec.isStore  = 1'b1;   // mem[rs1 + sImm] <- rs2
         opAluImm: dec.isAluImm = 1'b1;   // rd <- rs1 op iImm
         opAluReg: dec.isAluReg = 1'b1;   // rd <- rs1 op rs2
         opLui:    dec.isLui    = 1'b1;   // rd <- uImm
         opAuipc:  dec.isAuipc  = 1'b1;   // rd <- pc + uImm
         opBranch: dec.isBranch = 1'b1;   // pc <- pc + bImm when taken
         opJal:    dec.isJal    = 1'b1;   // rd <- pc + 4, pc <- pc + jImm
         opJalr:   dec.isJalr   = 1'b1;   // rd <- pc + 4, pc <- rs1 + iImm
         // No CSRs in this core, SYSTEM falls through as a no-op
         opSystem: ;
         default:  ;                      // Unknown opcodes also retire as no-ops
      endcase
   end

endmodule

// ==== src/rvLoadStore.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Load/store alignment for a 32-bit word memory, combinational
// Effective address, byte and halfword extraction with extension,
// store lane replication and byte write mask
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvLoadStore (
   input  rvPkg::decodedT               dec,
   input  rvPkg::wordT                  rs1Val,
   input  rvPkg::wordT                  rs2Val,
   input  rvPkg::wordT                  rdata,
   output logic [rvPkg::addrWidth-1:0]  lsAddr,
   output rvPkg::wordT                  loadData,
   output rvPkg::wordT                  storeData,
   output logic [3:0]                   storeMask
);
   import rvPkg::*;

   wordT        offset;
   logic        byteAccess;
   logic        halfAccess;
   logic [15:0] loadHalf;
   logic [7:0]  loadByte;
   logic        loadSign;

   // S immediate for stores, I immediate for loads
   assign offset = dec.isStore ? dec.sImm : dec.iImm;
   assign lsAddr = rs1Val[addrWidth-1:0] + offset[addrWidth-1:0];

   // funct3[1:0] gives size: 00 byte, 01 halfword, 10 word
   assign byteAccess = (dec.funct3[1:0] == 2'b00);
   assign halfAccess = (dec.funct3[1:0] == 2'b01);

   assign loadHalf = lsAddr[1] ? rdata[31:16] : rdata[15:0];
   assign loadByte = lsAddr[0] ? loadHalf[15:8] : loadHalf[7:0];

   // funct3[2] set for LBU / LHU
   assign loadSign = ~dec.funct3[2] & (byteAccess ? loadByte[7] : loadHalf[15]);

   assign loadData = byteAccess ? {{24{loadSign}}, loadByte} :
                     halfAccess ? {{16{loadSign}}, loadHalf} :
                                  rdata;

   // Low bytes of rs2 copied into every lane they may land in
   assign storeData[7:0]   = rs2Val[7:0];
   assign storeData[15:8]  = lsAddr[0] ? rs2Val[7:0] : rs2Val[15:8];
   assign storeData[23:16] = lsAddr[1] ? rs2Val[7:0] : rs2Val[23:16];
   assign storeData[31:24] = lsAddr[0] ? rs2Val[7:0] :
                             lsAddr[1] ? rs2Val[15:8] : rs2Val[31:24];

   // Byte lane enables
   always_comb begin
      if (byteAccess) begin
         storeMask = 4'b0001 << lsAddr[1:0];
      end else if (halfAccess) begin
         storeMask = lsAddr[1] ? 4'b1100 : 4'b0011;
      end else begin
         storeMask = 4'b1111;     // Whole word
      end
   end

endmodule

// ==== src/rvPkg.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Shared definitions for the multi-cycle RV32I core
// Word and address widths, reset address, major opcodes
// One-hot state encoding of the core FSM
// Decoded instruction record and the memory bus request/response structs
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
package rvPkg;

   localparam int xlen      = 32;        // Data word width
   localparam int addrWidth = 24;        // Implemented address bits, rest padded with 0

   typedef logic [4:0]      regIdxT;     // Register index
   typedef logic [xlen-1:0] wordT;

   localparam wordT resetAddr = 32'h0000_0000;   // First fetch
   localparam wordT nopInstr  = 32'h0000_0013;   // ADDI x0, x0, 0

   // Major opcodes, instruction bits 6..2
   localparam logic [4:0] opLoad   = 5'b00000;
   localparam logic [4:0] opStore  = 5'b01000;
   localparam logic [4:0] opAluImm = 5'b00100;
   localparam logic [4:0] opAluReg = 5'b01100;
   localparam logic [4:0] opLui    = 5'b01101;
   localparam logic [4:0] opAuipc  = 5'b00101;
   localparam logic [4:0] opBranch = 5'b11000;
   localparam logic [4:0] opJal    = 5'b11011;
   localparam logic [4:0] opJalr   = 5'b11001;
   localparam logic [4:0] opSystem = 5'b11100;   // CSR, ECALL, EBREAK

   // One-hot FSM
   localparam int numStates    = 4;
   localparam int fetchBit     = 0;
   localparam int waitInstrBit = 1;
   localparam int executeBit   = 2;
   localparam int waitMemBit   = 3;

   typedef logic [numStates-1:0] stateT;

   localparam stateT fetchState     = stateT'(1 << fetchBit);
   localparam stateT waitInstrState = stateT'(1 << waitInstrBit);
   localparam stateT executeState   = stateT'(1 << executeBit);
   localparam stateT waitMemState   = stateT'(1 << waitMemBit);

   typedef struct packed {
      regIdxT     rd;
      regIdxT     rs1Id;
      regIdxT     rs2Id;
      logic [2:0] funct3;
      logic [7:0] funct3Is;      // funct3Is[n] set when funct3 == n
      logic       subBit;        // instr[30], SUB and SRA
      logic       regOpBit;      // instr[5], register form of ALU ops
      wordT       iImm;
      wordT       sImm;
      wordT       bImm;
      wordT       uImm;
      wordT       jImm;
      logic       isLoad;
      logic       isStore;
      logic       isAluImm;
      logic       isAluReg;
      logic       isLui;
      logic       isAuipc;
      logic       isBranch;
      logic       isJal;
      logic       isJalr;
   } decodedT;

   typedef struct packed {
      wordT       addr;
      wordT       wdata;
      logic [3:0] wmask;         // Byte enables, non-zero starts a write
      logic       rstrb;         // One-cycle read pulse
   } memReqT;

   typedef struct packed {
      wordT rdata;
      logic rbusy;
      logic wbusy;
   } memRspT;

endpackage

// ==== src/rvRegFile.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// 32 x 32 integer register file
// Both source operands registered on load, one write port
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvRegFile (
   input  logic          clk,
   input  logic          load,       // Latch rs1Val/rs2Val
   input  rvPkg::regIdxT rs1Id,
   input  rvPkg::regIdxT rs2Id,
   output rvPkg::wordT   rs1Val,
   output rvPkg::wordT   rs2Val,
   input  logic          writeEn,
   input  rvPkg::regIdxT rd,
   input  rvPkg::wordT   writeData
);
   import rvPkg::*;

   wordT regs [32];

   // Entry 0 is never written
   always_ff @(posedge clk) begin
      if (writeEn && rd != '0) begin
         regs[rd] <= writeData;
      end
   end

   // x0 reads as zero whatever the array holds
   always_ff @(posedge clk) begin
      if (load) begin
         rs1Val <= (rs1Id == '0) ? '0 : regs[rs1Id];
         rs2Val <= (rs2Id == '0) ? '0 : regs[rs2Id];
      end
   end

endmodule

// ==== tests/coreInput.txt ====
# p <instruction word>, loaded from address 0 upward
# e <store addr> <store data> <byte mask>, in program order
p FFD00093
p 12345137
p 002081B3
p 10302023
e 00000100 12344FFD F
p 4010D213
p 10402223
e 00000104 FFFFFFFE F
p 00100F93
p 3FF02E23
e 000003FC 00000001 F
p 0000C463
p 10102423
p 008002EF
p 10002623
p 10502823
e 00000110 0000002C F
p 00200F93
p 3FF02E23
e 000003FC 00000002 F
p 201000A3
e 00000200 FDFFFDFD 2
p 20100303
p 20602223
e 00000204 FFFFFFFD F
p 20104383
p 20702423
e 00000208 000000FD F
p 00300F93
p 3FF02E23
e 000003FC 00000003 F
p 0000006F

// ==== tests/rvCoreTb.sv ====
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
// Testbench for the multi-cycle RV32I core
// Word memory model with random read/write busy
// Program and expected stores from the input data file
// Store checking, per-test report and watchdog
//~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~~
module rvCoreTb;
   import rvPkg::*;

   typedef struct packed {
      wordT       addr;
      wordT       data;
      logic [3:0] mask;
   } storeT;

   logic          clk;
   logic          reset;
   memReqT        memReq;
   memRspT        memRsp;

   wordT          mem [256];       // 1 KiB word memory, index is addr[9:2]
   storeT         expQ [$];        // Expected stores in program order
   int unsigned   busyLeft;
   int            numWords;
   int            testErrs;        // Errors in the running test
   int            totalErrs;
   int            passCount;
   int            failCount;
   logic          loaded;
   logic          done;

   rvCore dut0 (
      .clk    (clk),
      .reset  (reset),
      .memReq (memReq),
      .memRsp (memRsp)
   );

   always #2 clk = ~clk;

   // Program lines fill memory in order, expect lines queue stores
   task automatic readInput(output logic ok);
      int    fd;
      int    n;
      string line;
      string kind;
      wordT  a;
      wordT  b;
      wordT  c;
      fd = $fopen("tests/coreInput.txt", "r");
      ok = (fd != 0);
      if (ok) begin
         while (!$feof(fd)) begin
            n = $fgets(line, fd);
            if (n > 1 && line.getc(0) != 8'h23) begin   // Skip # comments
               n = $sscanf(line, "%s %h %h %h", kind, a, b, c);
               if (kind == "p") begin
                  mem[numWords] = a;
                  numWords++;
               end else if (kind == "e") begin
                  expQ.push_back({a, b, c[3:0]});
               end
            end
         end
         $fclose(fd);
      end
   endtask

   // Compare one store on the bus with the head of the queue
   task automatic checkStore();
      storeT exp;
      wordT  wordAddr;
      wordAddr = {memReq.addr[xlen-1:2], 2'b00};   // Lane given by the mask
      if (expQ.size() == 0) begin
         $display("Unexpected store at time %0t to %h", $time, memReq.addr);
         totalErrs++;
      end else begin
         exp = expQ.pop_front();
         if (wordAddr != exp.addr || memReq.wdata != exp.data ||
             memReq.wmask != exp.mask) begin
            $display("[ERROR] %0t: store addr %h data %h mask %b, expected %h %h %b",
                     $time, memReq.addr, memReq.wdata, memReq.wmask,
                     exp.addr, exp.data, exp.mask);
            testErrs++;
            totalErrs++;
         end
         if (exp.addr == 32'h0000_03FC) begin   // Test marker store
            if (testErrs == 0) passCount++;
            else failCount++;
            $display("Test %0d %s", exp.data, (testErrs == 0) ? "passed" : "failed");
            testErrs = 0;
            if (expQ.size() == 0) done <= 1'b1;
         end
      end
   endtask

   // Memory model, data one cycle after the strobe, then 0..3 busy cycles
   always @(posedge clk) begin
      int unsigned n;
      wordT        merged;
      if (busyLeft != 0) begin
         busyLeft <= busyLeft - 1;
         if (busyLeft == 1) begin
            memRsp.rbusy <= 1'b0;
            memRsp.wbusy <= 1'b0;
         end
      end
      if (memReq.rstrb) begin
         n = $urandom % 4;
         memRsp.rdata <= mem[memReq.addr[9:2]];
         memRsp.rbusy <= (n != 0);
         busyLeft     <= n;
      end
      if (memReq.wmask != 4'b0000) begin
         n = $urandom % 4;
         merged = mem[memReq.addr[9:2]];
         for (int i = 0; i < 4; i++) begin
            if (memReq.wmask[i]) merged[8*i +: 8] = memReq.wdata[8*i +: 8];
         end
         mem[memReq.addr[9:2]] = merged;
         memRsp.wbusy <= (n != 0);
         busyLeft     <= n;
         checkStore();
      end
   end

   initial begin : watchdog
      wait (loaded);
      #(numWords * 40 * 4);
      $display("Timeout, the core hung before all expected stores were seen");
      $display("Some tests failed");
      $finish;
   end

   initial begin
      logic fileOk;
      clk       = 1'b0;
      reset     = 1'b0;
      memRsp    = '0;
      busyLeft  = 0;
      numWords  = 0;
      testErrs  = 0;
      totalErrs = 0;
      passCount = 0;
      failCount = 0;
      done      = 1'b0;
      loaded    = 1'b0;
      seedRandom();
      for (int i = 0; i < 256; i++) begin
         mem[i] = '0;
      end
      readInput(fileOk);
      if (!fileOk) begin
         $display("Could not open the input data file");
         $display("Some tests failed");
         $finish;
      end else begin
         loaded = 1'b1;
         repeat (3) @(posedge clk);
         reset <= 1'b1;                  // Release after 3 cycles
         wait (done);
         $display("Tests passed %0d, failed %0d, store errors %0d",
                  passCount, failCount, totalErrs);
         if (failCount == 0 && totalErrs == 0) begin
            $display("All tests passed");
         end else begin
            $display("Some tests failed");
         end
         $finish;
      end
   end

   // One seed for the whole run
   task automatic seedRandom();
      void'($urandom(32'h0c396a5c));
   endtask

endmodule
